//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [31:0] pc_t;
	// byte address with the low two bits dropped
	typedef logic [29:0] word_addr_t;

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int REG_COUNT = 32;

	typedef enum logic [5:0] {
		op_ty_base = 6'b100000,
		op_addi    = 6'b101000,
		op_ori     = 6'b101100,
		op_xori    = 6'b101011,
		op_movi    = 6'b100010,
		op_lwi     = 6'b000010,
		op_swi     = 6'b001010,
		op_ty_ls   = 6'b011100,
		op_ty_b    = 6'b100110,
		op_jj      = 6'b100100
	} opcode_e;

	typedef enum logic [4:0] {
		base_add   = 5'b00000,
		base_sub   = 5'b00001,
		base_and   = 5'b00010,
		base_xor   = 5'b00011,
		base_or    = 5'b00100,
		base_slli  = 5'b01000,
		base_srli  = 5'b01001,
		base_rotri = 5'b01011
	} base_op_e;

	localparam logic [7:0] LS_LW = 8'h02;
	localparam logic [7:0] LS_SW = 8'h0a;
	localparam logic BR_BEQ = 1'b0;
	localparam logic BR_BNE = 1'b1;

	typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump} pc_sel_e;

	typedef enum logic [2:0] {
		src2_reg_b,
		src2_imm,
		src2_imm_word,
		src2_rb_scaled,
		src2_reg_b_compare
	} src2_sel_e;

	typedef enum logic [1:0] {ext_shamt5, ext_sign15, ext_zero15, ext_sign20} ext_sel_e;

	typedef enum logic [1:0] {wb_alu, wb_imm, wb_mem} wb_sel_e;

	typedef enum logic [2:0] {
		ph_fetch,
		ph_decode,
		ph_execute,
		ph_memaccess,
		ph_writeback
	} phase_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_srl,
		alu_sll,
		alu_ror
	} alu_op_e;

	typedef struct packed {
		alu_op_e   alu_op;
		src2_sel_e src2_sel;
		ext_sel_e  ext_sel;
		wb_sel_e   wb_sel;
		logic      dm_read;
		logic      dm_write;
		logic      reg_write;
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rt;
	} ctrl_t;

	typedef struct packed {
		logic fetch;
		logic decode;
		logic execute;
		logic memaccess;
		logic writeback;
	} phase_en_t;

	typedef struct packed {
		reg_addr_t rt;
		word_t     data;
	} reg_write_t;

	typedef struct packed {
		word_addr_t addr;
		word_t      data;
	} mem_write_t;

endpackage

`default_nettype wire

//--- src/alu.sv
`default_nettype none

module alu (
	input  cpu_pkg::alu_op_e op,
	input  cpu_pkg::word_t   x,
	input  cpu_pkg::word_t   y,
	output cpu_pkg::word_t   result,
	output logic             zero
);
	import cpu_pkg::*;

	logic [4:0] shamt;
	logic [63:0] rot;

	assign shamt = y[4:0];
	// rotate right as a shift of the doubled word
	assign rot = {x, x} >> shamt;

	always_comb begin
		case (op)
			alu_sub: result = x - y;
			alu_and: result = x & y;
			alu_or: result = x | y;
			alu_xor: result = x ^ y;
			alu_srl: result = x >> shamt;
			alu_sll: result = x << shamt;
			alu_ror: result = rot[31:0];
			default: result = x + y;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- src/register_file.sv
`default_nettype none

module register_file (
	input  logic               clock,
	input  logic               reset,
	input  cpu_pkg::reg_addr_t ra,
	input  cpu_pkg::reg_addr_t rb,
	input  cpu_pkg::reg_addr_t rt_read,
	output cpu_pkg::word_t     a,
	output cpu_pkg::word_t     b,
	output cpu_pkg::word_t     t,
	input  logic               write,
	input  cpu_pkg::reg_addr_t write_addr,
	input  cpu_pkg::word_t     write_data
);
	import cpu_pkg::*;

	word_t regs [REG_COUNT];

	// r0 is an ordinary register here
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write) begin
			regs[write_addr] <= write_data;
		end
	end

	assign a = regs[ra];
	assign b = regs[rb];
	assign t = regs[rt_read];

endmodule

`default_nettype wire

//--- src/word_memory.sv
`default_nettype none

module word_memory #(
	parameter int WORDS = 256
) (
	input  logic                clock,
	input  logic                write,
	input  cpu_pkg::word_addr_t write_addr,
	input  cpu_pkg::word_addr_t read_addr,
	input  cpu_pkg::word_t      write_data,
	output cpu_pkg::word_t      read_data
);
	import cpu_pkg::*;

	localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

	word_t mem [WORDS];

	always_ff @(posedge clock) begin
		if (write && write_addr < WORDS) begin
			mem[write_addr[AW-1:0]] <= write_data;
		end
	end

	// reads past the end give zero
	assign read_data = (read_addr < WORDS) ? mem[read_addr[AW-1:0]] : '0;

	write_in_range: assert property (@(posedge clock) write |-> write_addr < WORDS);

endmodule

`default_nettype wire

//--- src/datapath.sv
`default_nettype none

module datapath (
	input  logic                clock,
	input  logic                reset,
	input  cpu_pkg::phase_en_t  phase,
	input  cpu_pkg::ctrl_t      ctrl,
	input  cpu_pkg::word_t      ir,
	input  cpu_pkg::pc_sel_e    pc_select,
	input  cpu_pkg::word_t      mem_rdata,
	output cpu_pkg::pc_t        pc,
	output logic                alu_zero,
	output cpu_pkg::word_addr_t dm_addr,
	output cpu_pkg::word_t      dm_wdata,
	output cpu_pkg::reg_write_t commit,
	output logic                commit_valid
);
	import cpu_pkg::*;

	word_t rf_a;
	word_t rf_b;
	word_t rf_t;
	word_t op_a;
	word_t op_b;
	word_t op_t;
	word_t ext_imm;
	word_t src2;
	word_t alu_result;
	word_t result_q;
	word_t load_q;
	logic alu_zero_now;
	pc_t branch_offset;
	pc_t jump_offset;

	register_file u_register_file (
		.clock(clock),
		.reset(reset),
		.ra(ctrl.ra),
		.rb(ctrl.rb),
		.rt_read(ctrl.rt),
		.a(rf_a),
		.b(rf_b),
		.t(rf_t),
		.write(commit_valid),
		.write_addr(commit.rt),
		.write_data(commit.data)
	);

	always_comb begin
		case (ctrl.ext_sel)
			ext_sign15: ext_imm = {{17{ir[14]}}, ir[14:0]};
			ext_zero15: ext_imm = {17'b0, ir[14:0]};
			ext_sign20: ext_imm = {{12{ir[19]}}, ir[19:0]};
			default: ext_imm = {27'b0, ir[14:10]};
		endcase
	end

	always_comb begin
		case (ctrl.src2_sel)
			src2_imm: src2 = ext_imm;
			src2_imm_word: src2 = {{15{ir[14]}}, ir[14:0], 2'b00};
			// indexed access scales rb by sv
			src2_rb_scaled: src2 = op_b << ir[9:8];
			src2_reg_b_compare: src2 = op_t;
			default: src2 = op_b;
		endcase
	end

	alu u_alu (
		.op(ctrl.alu_op),
		.x(op_a),
		.y(src2),
		.result(alu_result),
		.zero(alu_zero_now)
	);

	always_ff @(posedge clock) begin
		if (phase.decode) begin
			op_a <= rf_a;
			op_b <= rf_b;
			op_t <= rf_t;
		end
		if (phase.execute) begin
			result_q <= alu_result;
		end
		if (phase.memaccess && ctrl.dm_read) begin
			load_q <= mem_rdata;
		end
	end

	assign branch_offset = {{16{ir[13]}}, ir[13:0], 2'b00};
	assign jump_offset = {{6{ir[23]}}, ir[23:0], 2'b00};

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			alu_zero <= 1'b0;
		end else begin
			if (phase.execute) begin
				alu_zero <= alu_zero_now;
			end
			// offsets relative to this instruction's pc
			if (phase.writeback) begin
				case (pc_select)
					pc_branch: pc <= pc + branch_offset;
					pc_jump: pc <= pc + jump_offset;
					default: pc <= pc + 32'd4;
				endcase
			end
		end
	end

	assign dm_addr = result_q[31:2];
	assign dm_wdata = op_t;

	always_comb begin
		commit.rt = ctrl.rt;
		case (ctrl.wb_sel)
			wb_imm: commit.data = ext_imm;
			wb_mem: commit.data = load_q;
			default: commit.data = result_q;
		endcase
	end

	assign commit_valid = phase.writeback && ctrl.reg_write;

endmodule

`default_nettype wire

//--- controller/controller.sv
`default_nettype none

module controller (
	input  logic              clock,
	input  logic              reset,
	input  cpu_pkg::word_t    instr,
	input  logic              alu_zero,
	output cpu_pkg::word_t    ir,
	output cpu_pkg::phase_en_t phase,
	output cpu_pkg::ctrl_t    ctrl,
	output cpu_pkg::pc_sel_e  pc_select
);
	import cpu_pkg::*;

	phase_e state;
	phase_e state_next;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= ph_fetch;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		phase = '0;
		case (state)
			ph_fetch: begin
				phase.fetch = 1'b1;
				state_next = ph_decode;
			end
			ph_decode: begin
				phase.decode = 1'b1;
				state_next = ph_execute;
			end
			ph_execute: begin
				phase.execute = 1'b1;
				state_next = ph_memaccess;
			end
			ph_memaccess: begin
				phase.memaccess = 1'b1;
				state_next = ph_writeback;
			end
			ph_writeback: begin
				phase.writeback = 1'b1;
				state_next = ph_fetch;
			end
			default: begin
				state_next = ph_fetch;
			end
		endcase
	end

	// instruction register held for the rest of the instruction
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ir <= '0;
		end else if (phase.fetch) begin
			ir <= instr;
		end
	end

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_add;
		ctrl.src2_sel = src2_reg_b;
		ctrl.ext_sel = ext_shamt5;
		ctrl.wb_sel = wb_alu;
		ctrl.rt = ir[24:20];
		ctrl.ra = ir[19:15];
		ctrl.rb = ir[14:10];
		case (ir[30:25])
			op_ty_base: begin
				ctrl.reg_write = 1'b1;
				case (ir[4:0])
					base_add: ctrl.alu_op = alu_add;
					base_sub: ctrl.alu_op = alu_sub;
					base_and: ctrl.alu_op = alu_and;
					base_xor: ctrl.alu_op = alu_xor;
					base_or: ctrl.alu_op = alu_or;
					base_slli: begin
						ctrl.alu_op = alu_sll;
						ctrl.src2_sel = src2_imm;
					end
					base_srli: begin
						ctrl.alu_op = alu_srl;
						ctrl.src2_sel = src2_imm;
					end
					base_rotri: begin
						ctrl.alu_op = alu_ror;
						ctrl.src2_sel = src2_imm;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			op_addi: begin
				ctrl.src2_sel = src2_imm;
				ctrl.ext_sel = ext_sign15;
				ctrl.reg_write = 1'b1;
			end
			op_ori: begin
				ctrl.alu_op = alu_or;
				ctrl.src2_sel = src2_imm;
				ctrl.ext_sel = ext_zero15;
				ctrl.reg_write = 1'b1;
			end
			op_xori: begin
				ctrl.alu_op = alu_xor;
				ctrl.src2_sel = src2_imm;
				ctrl.ext_sel = ext_zero15;
				ctrl.reg_write = 1'b1;
			end
			op_movi: begin
				ctrl.src2_sel = src2_imm;
				ctrl.ext_sel = ext_sign20;
				ctrl.wb_sel = wb_imm;
				ctrl.reg_write = 1'b1;
			end
			op_lwi: begin
				ctrl.src2_sel = src2_imm_word;
				ctrl.wb_sel = wb_mem;
				ctrl.dm_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_swi: begin
				ctrl.src2_sel = src2_imm_word;
				ctrl.dm_write = 1'b1;
			end
			op_ty_ls: begin
				ctrl.src2_sel = src2_rb_scaled;
				ctrl.wb_sel = wb_mem;
				if (ir[7:0] == LS_LW) begin
					ctrl.dm_read = 1'b1;
					ctrl.reg_write = 1'b1;
				end else if (ir[7:0] == LS_SW) begin
					ctrl.dm_write = 1'b1;
				end
			end
			op_ty_b: begin
				// equality test through the subtract
				ctrl.alu_op = alu_sub;
				ctrl.src2_sel = src2_reg_b_compare;
			end
			default: begin
			end
		endcase
	end

	// zero flag is the one latched in execute
	always_comb begin
		case (ir[30:25])
			op_ty_b: begin
				if (ir[14] == BR_BEQ && alu_zero) begin
					pc_select = pc_branch;
				end else if (ir[14] == BR_BNE && !alu_zero) begin
					pc_select = pc_branch;
				end else begin
					pc_select = pc_seq;
				end
			end
			op_jj: pc_select = pc_jump;
			default: pc_select = pc_seq;
		endcase
	end

	phase_one_hot: assert property (@(posedge clock) disable iff (reset) $onehot(phase));

	no_read_write: assert property (@(posedge clock) disable iff (reset)
		!(ctrl.dm_read && ctrl.dm_write));

endmodule

`default_nettype wire

//--- src/cpu_top.sv
`default_nettype none

module cpu_top (
	input  logic                clock,
	input  logic                reset,
	input  logic                prog_write,
	input  cpu_pkg::word_addr_t prog_addr,
	input  cpu_pkg::word_t      prog_data,
	output cpu_pkg::reg_write_t reg_commit,
	output logic                reg_commit_valid,
	output cpu_pkg::mem_write_t mem_store,
	output logic                mem_store_valid
);
	import cpu_pkg::*;

	word_t instr;
	word_t ir;
	phase_en_t phase;
	ctrl_t ctrl;
	pc_sel_e pc_select;
	pc_t pc;
	logic alu_zero;
	word_addr_t dm_addr;
	word_t dm_wdata;
	word_t mem_rdata;

	controller u_controller (
		.clock(clock),
		.reset(reset),
		.instr(instr),
		.alu_zero(alu_zero),
		.ir(ir),
		.phase(phase),
		.ctrl(ctrl),
		.pc_select(pc_select)
	);

	datapath u_datapath (
		.clock(clock),
		.reset(reset),
		.phase(phase),
		.ctrl(ctrl),
		.ir(ir),
		.pc_select(pc_select),
		.mem_rdata(mem_rdata),
		.pc(pc),
		.alu_zero(alu_zero),
		.dm_addr(dm_addr),
		.dm_wdata(dm_wdata),
		.commit(reg_commit),
		.commit_valid(reg_commit_valid)
	);

	// program load port shares the instruction memory write side
	word_memory #(
		.WORDS(IMEM_WORDS)
	) u_imem (
		.clock(clock),
		.write(prog_write),
		.write_addr(prog_addr),
		.read_addr(pc[31:2]),
		.write_data(prog_data),
		.read_data(instr)
	);

	assign mem_store_valid = phase.memaccess && ctrl.dm_write;
	assign mem_store = '{addr: dm_addr, data: dm_wdata};

	word_memory #(
		.WORDS(DMEM_WORDS)
	) u_dmem (
		.clock(clock),
		.write(mem_store_valid),
		.write_addr(dm_addr),
		.read_addr(dm_addr),
		.write_data(dm_wdata),
		.read_data(mem_rdata)
	);

endmodule

`default_nettype wire

//--- tests/tb_cpu.sv
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;

	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int INSTR_CYCLES = 5;

	logic clock;
	logic reset;
	logic prog_write;
	word_addr_t prog_addr;
	word_t prog_data;
	reg_write_t reg_commit;
	logic reg_commit_valid;
	mem_write_t mem_store;
	logic mem_store_valid;

	word_t prog [$];
	reg_write_t exp_commits [$];
	reg_write_t got_commits [$];
	mem_write_t exp_stores [$];
	mem_write_t got_stores [$];
	int commit_cycles [$];
	word_t model [32];
	word_t mem_model [word_addr_t];
	word_t lcg_state = 32'h1444;
	int cycle_count = 0;
	int cycle_budget = 100;
	int errors = 0;
	int checks = 0;

	cpu_top u_cpu_top (
		.clock(clock),
		.reset(reset),
		.prog_write(prog_write),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.reg_commit(reg_commit),
		.reg_commit_valid(reg_commit_valid),
		.mem_store(mem_store),
		.mem_store_valid(mem_store_valid)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	// outputs settle by the falling edge
	always @(negedge clock) begin
		if (reset) begin
			if (reg_commit_valid || mem_store_valid) begin
				$display("event seen while reset was high, cycle %0d", cycle_count);
				errors++;
			end
		end else begin
			if (reg_commit_valid) begin
				got_commits.push_back(reg_commit);
				commit_cycles.push_back(cycle_count);
			end
			if (mem_store_valid) begin
				got_stores.push_back(mem_store);
			end
		end
	end

	// budget grows as each test program is loaded
	initial begin
		while (cycle_count <= cycle_budget) begin
			@(posedge clock);
		end
		$display("watchdog expired after %0d cycles, errors so far %0d", cycle_count, errors);
		$display("=== FAIL ===");
		$finish;
	end

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic word_t encode(opcode_e opc, reg_addr_t rt, reg_addr_t ra,
			logic [14:0] low);
		return {1'b0, opc, rt, ra, low};
	endfunction

	function automatic word_t movi_word(reg_addr_t rt, logic [19:0] imm20);
		return {1'b0, op_movi, rt, imm20};
	endfunction

	function automatic word_t jump_word(logic [23:0] off24);
		return {1'b0, op_jj, 1'b0, off24};
	endfunction

	function automatic word_t offset_word(logic [14:0] imm15);
		int offset;
		offset = $signed(imm15);
		return offset * 4;
	endfunction

	function automatic word_t rotate_right(word_t x, int unsigned s);
		if (s == 0) begin
			return x;
		end
		return (x >> s) | (x << (32 - s));
	endfunction

	task automatic compare_commit(string name, reg_write_t expected, reg_write_t actual);
		checks++;
		if (expected !== actual) begin
			$display("[ERROR] %s: commit expected rt=%0d data=%h, actual rt=%0d data=%h",
				name, expected.rt, expected.data, actual.rt, actual.data);
			errors++;
		end
	endtask

	task automatic compare_store(string name, mem_write_t expected, mem_write_t actual);
		checks++;
		if (expected !== actual) begin
			$display("[ERROR] %s: store expected addr=%h data=%h, actual addr=%h data=%h",
				name, expected.addr, expected.data, actual.addr, actual.data);
			errors++;
		end
	endtask

	task automatic begin_test();
		prog.delete();
		exp_commits.delete();
		exp_stores.delete();
		mem_model.delete();
		foreach (model[i]) begin
			model[i] = '0;
		end
	endtask

	task automatic emit(word_t w);
		prog.push_back(w);
	endtask

	task automatic expect_commit(reg_addr_t rt, word_t value);
		reg_write_t c;
		c.rt = rt;
		c.data = value;
		exp_commits.push_back(c);
		model[rt] = value;
	endtask

	task automatic expect_store(word_t byte_addr, reg_addr_t rt);
		mem_write_t s;
		s.addr = byte_addr[31:2];
		s.data = model[rt];
		exp_stores.push_back(s);
		mem_model[s.addr] = s.data;
	endtask

	task automatic movi(reg_addr_t rt, logic [19:0] imm20);
		int value;
		value = $signed(imm20);
		emit(movi_word(rt, imm20));
		expect_commit(rt, value);
	endtask

	task automatic reg_op(base_op_e op, reg_addr_t rt, reg_addr_t ra, reg_addr_t rb);
		word_t v;
		emit(encode(op_ty_base, rt, ra, {rb, 5'b0, op}));
		case (op)
			base_sub: v = model[ra] - model[rb];
			base_and: v = model[ra] & model[rb];
			base_or: v = model[ra] | model[rb];
			base_xor: v = model[ra] ^ model[rb];
			default: v = model[ra] + model[rb];
		endcase
		expect_commit(rt, v);
	endtask

	task automatic shift_op(base_op_e op, reg_addr_t rt, reg_addr_t ra, logic [4:0] shamt);
		word_t v;
		emit(encode(op_ty_base, rt, ra, {shamt, 5'b0, op}));
		case (op)
			base_slli: v = model[ra] << shamt;
			base_srli: v = model[ra] >> shamt;
			default: v = rotate_right(model[ra], shamt);
		endcase
		expect_commit(rt, v);
	endtask

	task automatic imm_op(opcode_e op, reg_addr_t rt, reg_addr_t ra, logic [14:0] imm15);
		word_t v;
		int simm;
		simm = $signed(imm15);
		emit(encode(op, rt, ra, imm15));
		case (op)
			op_ori: v = model[ra] | {17'b0, imm15};
			op_xori: v = model[ra] ^ {17'b0, imm15};
			default: v = model[ra] + simm;
		endcase
		expect_commit(rt, v);
	endtask

	task automatic store_imm(reg_addr_t rt, reg_addr_t ra, logic [14:0] imm15);
		emit(encode(op_swi, rt, ra, imm15));
		expect_store(model[ra] + offset_word(imm15), rt);
	endtask

	task automatic store_indexed(reg_addr_t rt, reg_addr_t ra, reg_addr_t rb, logic [1:0] sv);
		emit(encode(op_ty_ls, rt, ra, {rb, sv, LS_SW}));
		expect_store(model[ra] + (model[rb] << sv), rt);
	endtask

	task automatic load_imm(reg_addr_t rt, reg_addr_t ra, logic [14:0] imm15);
		word_t a;
		a = model[ra] + offset_word(imm15);
		emit(encode(op_lwi, rt, ra, imm15));
		expect_commit(rt, mem_model[a[31:2]]);
	endtask

	task automatic load_indexed(reg_addr_t rt, reg_addr_t ra, reg_addr_t rb, logic [1:0] sv);
		word_t a;
		a = model[ra] + (model[rb] << sv);
		emit(encode(op_ty_ls, rt, ra, {rb, sv, LS_LW}));
		expect_commit(rt, mem_model[a[31:2]]);
	endtask

	// jump to itself so no further events follow
	task automatic halt();
		emit(jump_word(24'd0));
	endtask

	task automatic start_program();
		cycle_budget += prog.size() + RESET_CYCLES + INSTR_CYCLES * prog.size() + 40;
		@(posedge clock);
		reset <= 1'b1;
		foreach (prog[i]) begin
			@(posedge clock);
			prog_write <= 1'b1;
			prog_addr <= word_addr_t'(i);
			prog_data <= prog[i];
		end
		@(posedge clock);
		prog_write <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		got_commits.delete();
		got_stores.delete();
		commit_cycles.delete();
		reset <= 1'b0;
	endtask

	task automatic wait_events(string name, int n_commits, int n_stores);
		int waited;
		waited = 0;
		while ((got_commits.size() < n_commits || got_stores.size() < n_stores)
				&& waited < INSTR_CYCLES * prog.size() + 20) begin
			@(posedge clock);
			waited++;
		end
		if (got_commits.size() < n_commits || got_stores.size() < n_stores) begin
			$display("%s: timed out after %0d cycles waiting for %0d commits and %0d stores",
				name, waited, n_commits, n_stores);
			errors++;
		end
	endtask

	task automatic check_results(string name);
		checks += 2;
		if (got_commits.size() != exp_commits.size()) begin
			$display("[ERROR] %s: commit count expected %0d actual %0d",
				name, exp_commits.size(), got_commits.size());
			errors++;
		end
		if (got_stores.size() != exp_stores.size()) begin
			$display("[ERROR] %s: store count expected %0d actual %0d",
				name, exp_stores.size(), got_stores.size());
			errors++;
		end
		for (int i = 0; i < exp_commits.size() && i < got_commits.size(); i++) begin
			compare_commit(name, exp_commits[i], got_commits[i]);
		end
		for (int i = 0; i < exp_stores.size() && i < got_stores.size(); i++) begin
			compare_store(name, exp_stores[i], got_stores[i]);
		end
	endtask

	task automatic check_spacing(string name);
		for (int i = 1; i < commit_cycles.size(); i++) begin
			checks++;
			if (commit_cycles[i] - commit_cycles[i - 1] != INSTR_CYCLES) begin
				$display("[ERROR] %s: commit spacing expected %0d actual %0d",
					name, INSTR_CYCLES, commit_cycles[i] - commit_cycles[i - 1]);
				errors++;
			end
		end
	endtask

	task automatic run_and_check(string name);
		start_program();
		wait_events(name, exp_commits.size(), exp_stores.size());
		// let the halt loop spin to catch stray events
		repeat (2 * INSTR_CYCLES) @(posedge clock);
		check_results(name);
	endtask

	task automatic test_register_ops();
		begin_test();
		movi(5'd1, 20'hffff5);
		movi(5'd2, 20'h12345);
		reg_op(base_add, 5'd3, 5'd1, 5'd2);
		reg_op(base_sub, 5'd4, 5'd2, 5'd1);
		reg_op(base_and, 5'd5, 5'd1, 5'd2);
		reg_op(base_or, 5'd6, 5'd1, 5'd2);
		reg_op(base_xor, 5'd0, 5'd1, 5'd2);
		halt();
		run_and_check("register_ops");
		check_spacing("register_ops");
	endtask

	task automatic test_immediate_ops();
		begin_test();
		movi(5'd1, 20'd100);
		imm_op(op_addi, 5'd2, 5'd1, 15'h7ff6);
		imm_op(op_ori, 5'd3, 5'd1, 15'h4001);
		imm_op(op_xori, 5'd4, 5'd1, 15'h7f0f);
		movi(5'd5, 20'h80f0f);
		shift_op(base_slli, 5'd6, 5'd5, 5'd4);
		shift_op(base_srli, 5'd7, 5'd5, 5'd7);
		shift_op(base_rotri, 5'd8, 5'd5, 5'd12);
		shift_op(base_rotri, 5'd9, 5'd5, 5'd31);
		halt();
		run_and_check("immediate_ops");
	endtask

	task automatic test_memory();
		begin_test();
		movi(5'd1, 20'd64);
		movi(5'd2, 20'h5a5a5);
		movi(5'd3, 20'habcde);
		movi(5'd4, 20'd3);
		store_imm(5'd2, 5'd1, 15'd2);
		store_indexed(5'd3, 5'd1, 5'd4, 2'd2);
		store_imm(5'd4, 5'd1, 15'h7fff);
		load_imm(5'd5, 5'd1, 15'd2);
		load_indexed(5'd6, 5'd1, 5'd4, 2'd2);
		load_imm(5'd7, 5'd1, 15'h7fff);
		halt();
		run_and_check("memory");
	endtask

	task automatic test_control_flow();
		begin_test();
		movi(5'd1, 20'd5);
		movi(5'd2, 20'd5);
		movi(5'd3, 20'd6);
		// taken beq skips one word
		emit(encode(op_ty_b, 5'd2, 5'd1, {BR_BEQ, 14'd2}));
		emit(movi_word(5'd4, 20'h111));
		movi(5'd5, 20'h222);
		emit(encode(op_ty_b, 5'd2, 5'd1, {BR_BNE, 14'd2}));
		movi(5'd6, 20'h333);
		emit(encode(op_ty_b, 5'd3, 5'd1, {BR_BEQ, 14'd2}));
		movi(5'd10, 20'h444);
		emit(encode(op_ty_b, 5'd3, 5'd1, {BR_BNE, 14'd2}));
		emit(movi_word(5'd11, 20'h555));
		movi(5'd12, 20'h666);
		emit(jump_word(24'd3));
		emit(movi_word(5'd7, 20'h777));
		emit(movi_word(5'd8, 20'h888));
		movi(5'd9, 20'h999);
		halt();
		run_and_check("control_flow");
	endtask

	task automatic test_random_ops();
		reg_addr_t ra;
		reg_addr_t rb;
		reg_addr_t rt;
		base_op_e op;
		word_t r;
		begin_test();
		for (int i = 0; i < 20; i++) begin
			r = lcg_next();
			ra = r[31:27];
			rb = r[26:22];
			rt = r[21:17];
			if (rb == ra) begin
				rb = ra + 5'd1;
			end
			r = lcg_next();
			movi(ra, r[31:12]);
			r = lcg_next();
			movi(rb, r[31:12]);
			case (lcg_next() % 5)
				0: op = base_add;
				1: op = base_sub;
				2: op = base_and;
				3: op = base_or;
				default: op = base_xor;
			endcase
			reg_op(op, rt, ra, rb);
		end
		halt();
		run_and_check("random_ops");
		check_spacing("random_ops");
	endtask

	task automatic test_reset_restart();
		begin_test();
		for (int i = 1; i <= 6; i++) begin
			movi(reg_addr_t'(i), 20'(i * 32'h111));
		end
		halt();
		start_program();
		wait_events("reset_restart", 2, 0);
		for (int i = 0; i < 2 && i < got_commits.size(); i++) begin
			compare_commit("reset_restart", exp_commits[i], got_commits[i]);
		end
		// reset in the middle of the third instruction
		cycle_budget += RESET_CYCLES + INSTR_CYCLES * prog.size() + 20;
		@(posedge clock);
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		got_commits.delete();
		got_stores.delete();
		commit_cycles.delete();
		reset <= 1'b0;
		wait_events("reset_restart", exp_commits.size(), 0);
		repeat (2 * INSTR_CYCLES) @(posedge clock);
		check_results("reset_restart");
	endtask

	initial begin
		reset = 1'b1;
		prog_write = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		test_register_ops();
		test_immediate_ops();
		test_memory();
		test_control_flow();
		test_random_ops();
		test_reset_restart();
		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
common/cpu_pkg.sv
src/alu.sv
src/register_file.sv
src/word_memory.sv
src/datapath.sv
controller/controller.sv
src/cpu_top.sv
tests/tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
RTL_TOP ?= cpu_top
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS ?= -Wno-fatal
FAIL_TEXT ?= === FAIL ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary --timing --assert $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
